//--- prc_config.svh
`ifndef PRC_CONFIG_SVH
`define PRC_CONFIG_SVH

// Display timing
`define PRC_LINE_CYCLES 855
`define PRC_RENDER_LINE 24
`define PRC_LAST_LINE   66

// Frame buffer and tile map geometry
`define PRC_FB_COLUMNS  96
`define PRC_FB_PAGES    8
`define PRC_MAP_COLUMNS 12

// Bus widths
`define PRC_ADDR_W 24
`define PRC_DATA_W 8

`endif

//--- prc_reg_pkg.sv
`default_nettype none

package prc_reg_pkg;

    typedef logic [3:0] reg_offset_t;

    localparam reg_offset_t REG_MODE         = 4'd0;
    localparam reg_offset_t REG_RATE         = 4'd1;
    localparam reg_offset_t REG_MAP_BASE_LO  = 4'd2;
    localparam reg_offset_t REG_MAP_BASE_MID = 4'd3;
    localparam reg_offset_t REG_MAP_BASE_HI  = 4'd4;
    localparam reg_offset_t REG_COUNTER      = 4'd10;

    typedef logic [5:0] mode_t;

    localparam int MODE_MAP_BIT  = 1;
    localparam int MODE_COPY_BIT = 3;

    typedef logic [2:0] rate_sel_t;     // Divider select from rate bits 3:1
    typedef logic [3:0] frame_count_t;  // Frames skipped since the last active one

endpackage

`default_nettype wire

//--- prc_bus_pkg.sv
`default_nettype none

`include "prc_config.svh"

package prc_bus_pkg;

    // Work RAM
    localparam logic [`PRC_ADDR_W-1:0] FB_BASE  = 'h1000;
    localparam logic [`PRC_ADDR_W-1:0] MAP_BASE = 'h1360;

    // LCD controller ports
    localparam logic [`PRC_ADDR_W-1:0] LCD_CMD  = 'h20FE;
    localparam logic [`PRC_ADDR_W-1:0] LCD_DATA = 'h20FF;

    localparam logic [`PRC_DATA_W-1:0] LCD_COL_HI = 'h10;
    localparam logic [`PRC_DATA_W-1:0] LCD_COL_LO = 'h00;
    localparam logic [`PRC_DATA_W-1:0] LCD_PAGE   = 'hB0;  // Page number in the low bits

    typedef enum logic [1:0] {
        STAGE_IDLE,
        STAGE_MAP,
        STAGE_COPY
    } stage_t;

    typedef enum logic {
        READ,
        WRITE
    } bus_op_t;

endpackage

`default_nettype wire

//--- prc_regs.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module prc_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  prc_reg_pkg::reg_offset_t     paddr,
    input  logic [`PRC_DATA_W-1:0]       pwdata,
    output logic [`PRC_DATA_W-1:0]       prdata,
    output prc_reg_pkg::mode_t           mode,
    output prc_reg_pkg::rate_sel_t       rate_sel,
    output logic [`PRC_ADDR_W-1:0]       map_base,
    input  prc_reg_pkg::frame_count_t    frame_count,
    input  logic [6:0]                   line
);

    logic       wr_en;
    logic [3:0] rate_q;
    logic [4:0] base_lo;   // Tile base is 8-byte aligned
    logic [7:0] base_mid;
    logic [4:0] base_hi;

    assign wr_en    = psel && penable && pwrite;
    assign rate_sel = rate_q[3:1];
    assign map_base = {3'b000, base_hi, base_mid, base_lo, 3'b000};

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            mode     <= '0;
            rate_q   <= '0;
            base_lo  <= '0;
            base_mid <= '0;
            base_hi  <= '0;
        end
        else if (wr_en)
        begin
            case (paddr)
                prc_reg_pkg::REG_MODE:         mode     <= pwdata[5:0];
                prc_reg_pkg::REG_RATE:         rate_q   <= pwdata[3:0];
                prc_reg_pkg::REG_MAP_BASE_LO:  base_lo  <= pwdata[7:3];
                prc_reg_pkg::REG_MAP_BASE_MID: base_mid <= pwdata;
                prc_reg_pkg::REG_MAP_BASE_HI:  base_hi  <= pwdata[4:0];
                default:
                begin
                end
            endcase
        end
    end

    always_comb
    begin
        case (paddr)
            prc_reg_pkg::REG_MODE:         prdata = {2'b00, mode};
            prc_reg_pkg::REG_RATE:         prdata = {frame_count, rate_q};
            prc_reg_pkg::REG_MAP_BASE_LO:  prdata = map_base[7:0];
            prc_reg_pkg::REG_MAP_BASE_MID: prdata = map_base[15:8];
            prc_reg_pkg::REG_MAP_BASE_HI:  prdata = map_base[23:16];
            prc_reg_pkg::REG_COUNTER:      prdata = {1'b0, line};
            default:                       prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- prc_frame_timer.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module prc_frame_timer (
    input  logic                         clk,
    input  logic                         reset,
    input  prc_reg_pkg::rate_sel_t       rate_sel,
    input  logic                         render_enable,
    output prc_reg_pkg::frame_count_t    frame_count,
    output logic [6:0]                   line,
    output logic                         render_start,
    output logic                         irq_render_done
);

    localparam int CW = $clog2(`PRC_LINE_CYCLES);

    logic [CW-1:0]             cycle_cnt;
    prc_reg_pkg::rate_sel_t    last_sel;
    prc_reg_pkg::frame_count_t match;
    logic                      tick;
    logic                      active;

    // Divisor minus one
    always_comb
    begin
        case (rate_sel)
            3'd0:    match = 4'd2;   // /3
            3'd1:    match = 4'd5;   // /6
            3'd2:    match = 4'd8;   // /9
            3'd3:    match = 4'd11;  // /12
            3'd4:    match = 4'd1;   // /2
            3'd5:    match = 4'd3;   // /4
            3'd6:    match = 4'd5;   // /6
            default: match = 4'd7;   // /8
        endcase
    end

    assign tick            = cycle_cnt == CW'(`PRC_LINE_CYCLES - 1);
    assign active          = frame_count == match;
    assign irq_render_done = tick && active && line == 7'(`PRC_LAST_LINE);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            cycle_cnt    <= '0;
            line         <= 7'd1;
            frame_count  <= '0;
            last_sel     <= '0;
            render_start <= 1'b0;
        end
        else
        begin
            last_sel     <= rate_sel;
            render_start <= tick && active && render_enable &&
                            line == 7'(`PRC_RENDER_LINE - 1);
            cycle_cnt    <= tick ? '0 : cycle_cnt + 1'b1;

            if (tick)
            begin
                if (line == 7'(`PRC_LAST_LINE))
                begin
                    line        <= 7'd1;
                    frame_count <= active ? '0 : frame_count + 1'b1;
                end
                else
                    line <= line + 1'b1;
            end

            if (rate_sel != last_sel)
                frame_count <= '0;  // New divider restarts the skip count
        end
    end

endmodule

`default_nettype wire

//--- prc_render_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module prc_render_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         render_start,
    input  prc_reg_pkg::mode_t           mode,
    output logic                         map_start,
    output logic                         copy_start,
    input  logic                         map_req,
    input  logic [`PRC_ADDR_W-1:0]       map_addr,
    input  prc_bus_pkg::bus_op_t         map_op,
    input  logic [`PRC_DATA_W-1:0]       map_wdata,
    input  logic                         copy_req,
    input  logic [`PRC_ADDR_W-1:0]       copy_addr,
    input  prc_bus_pkg::bus_op_t         copy_op,
    input  logic [`PRC_DATA_W-1:0]       copy_wdata,
    output logic                         map_ack,
    output logic                         copy_ack,
    output logic [`PRC_DATA_W-1:0]       rdata,
    input  logic                         map_done,
    input  logic                         copy_done,
    output logic                         mem_req,
    output logic [`PRC_ADDR_W-1:0]       mem_addr,
    output prc_bus_pkg::bus_op_t         mem_op,
    output logic [`PRC_DATA_W-1:0]       mem_wdata,
    input  logic                         mem_ack,
    input  logic [`PRC_DATA_W-1:0]       mem_rdata,
    output logic                         irq_copy_complete
);

    prc_bus_pkg::stage_t stage;
    logic                map_sel;
    logic                copy_sel;

    assign map_sel  = stage == prc_bus_pkg::STAGE_MAP;
    assign copy_sel = stage == prc_bus_pkg::STAGE_COPY;

    // Only the active stage reaches the memory port
    assign mem_req   = (map_sel && map_req) || (copy_sel && copy_req);
    assign mem_addr  = copy_sel ? copy_addr : map_addr;
    assign mem_op    = copy_sel ? copy_op : map_op;
    assign mem_wdata = copy_sel ? copy_wdata : map_wdata;
    assign map_ack   = map_sel && mem_ack;
    assign copy_ack  = copy_sel && mem_ack;
    assign rdata     = mem_rdata;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            stage             <= prc_bus_pkg::STAGE_IDLE;
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_copy_complete <= 1'b0;
        end
        else
        begin
            map_start         <= 1'b0;
            copy_start        <= 1'b0;
            irq_copy_complete <= 1'b0;

            case (stage)
                prc_bus_pkg::STAGE_IDLE:
                begin
                    if (render_start && mode[prc_reg_pkg::MODE_MAP_BIT])
                    begin
                        stage     <= prc_bus_pkg::STAGE_MAP;
                        map_start <= 1'b1;
                    end
                    else if (render_start && mode[prc_reg_pkg::MODE_COPY_BIT])
                    begin
                        stage      <= prc_bus_pkg::STAGE_COPY;
                        copy_start <= 1'b1;
                    end
                end
                prc_bus_pkg::STAGE_MAP:
                begin
                    if (map_done && mode[prc_reg_pkg::MODE_COPY_BIT])
                    begin
                        stage      <= prc_bus_pkg::STAGE_COPY;
                        copy_start <= 1'b1;
                    end
                    else if (map_done)
                        stage <= prc_bus_pkg::STAGE_IDLE;
                end
                prc_bus_pkg::STAGE_COPY:
                begin
                    if (copy_done)
                    begin
                        stage             <= prc_bus_pkg::STAGE_IDLE;
                        irq_copy_complete <= 1'b1;
                    end
                end
                default: stage <= prc_bus_pkg::STAGE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- prc_map_draw.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module prc_map_draw (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    output logic                         req,
    output logic [`PRC_ADDR_W-1:0]       addr,
    output prc_bus_pkg::bus_op_t         op,
    output logic [`PRC_DATA_W-1:0]       wdata,
    input  logic                         ack,
    input  logic [`PRC_DATA_W-1:0]       rdata,
    output logic                         done,
    input  logic [`PRC_ADDR_W-1:0]       map_base
);

    localparam int AW = `PRC_ADDR_W;

    typedef enum logic [1:0] {
        STEP_INDEX,  // Tile index from the map
        STEP_TILE,   // Tile column byte
        STEP_WRITE   // Frame buffer store
    } step_t;

    step_t                  step;
    logic [2:0]             page;
    logic [6:0]             col;
    logic [`PRC_DATA_W-1:0] tile_idx;
    logic                   last_col;
    logic                   last_page;

    assign last_col  = col == 7'(`PRC_FB_COLUMNS - 1);
    assign last_page = page == 3'(`PRC_FB_PAGES - 1);
    assign op        = step == STEP_WRITE ? prc_bus_pkg::WRITE : prc_bus_pkg::READ;
    assign done      = ack && step == STEP_WRITE && last_col && last_page;

    always_comb
    begin
        case (step)
            STEP_INDEX: addr = prc_bus_pkg::MAP_BASE + AW'(page) * AW'(`PRC_MAP_COLUMNS) +
                               AW'(col[6:3]);
            STEP_TILE:  addr = map_base + AW'({tile_idx, 3'b000}) + AW'(col[2:0]);
            default:    addr = prc_bus_pkg::FB_BASE + AW'(page) * AW'(`PRC_FB_COLUMNS) +
                               AW'(col);
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            req  <= 1'b0;
            step <= STEP_INDEX;
            page <= '0;
            col  <= '0;
        end
        else if (start)
        begin
            req  <= 1'b1;
            step <= STEP_INDEX;
            page <= '0;
            col  <= '0;
        end
        else if (ack)
        begin
            case (step)
                STEP_INDEX: step <= STEP_TILE;
                STEP_TILE:  step <= STEP_WRITE;
                default:
                begin
                    step <= STEP_INDEX;
                    col  <= last_col ? '0 : col + 1'b1;
                    if (last_col && last_page)
                        req <= 1'b0;
                    else if (last_col)
                        page <= page + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack && step == STEP_INDEX)
            tile_idx <= rdata;
        if (ack && step == STEP_TILE)
            wdata <= rdata;
    end

endmodule

`default_nettype wire

//--- prc_frame_copy.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module prc_frame_copy (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         ack,
    input  logic [`PRC_DATA_W-1:0]       rdata,
    output logic                         req,
    output logic [`PRC_ADDR_W-1:0]       addr,
    output prc_bus_pkg::bus_op_t         op,
    output logic [`PRC_DATA_W-1:0]       wdata,
    output logic                         done
);

    localparam int AW = `PRC_ADDR_W;
    localparam int DW = `PRC_DATA_W;

    typedef enum logic [2:0] {
        CP_COL_HI,
        CP_COL_LO,
        CP_PAGE,
        CP_READ,   // Fetch from the frame buffer
        CP_WRITE   // Push to LCD data
    } copy_step_t;

    copy_step_t             step;
    logic [2:0]             page;
    logic [6:0]             col;
    logic [`PRC_DATA_W-1:0] pix;
    logic                   last_col;
    logic                   last_page;

    assign last_col  = col == 7'(`PRC_FB_COLUMNS - 1);
    assign last_page = page == 3'(`PRC_FB_PAGES - 1);
    assign op        = step == CP_READ ? prc_bus_pkg::READ : prc_bus_pkg::WRITE;
    assign done      = ack && step == CP_WRITE && last_col && last_page;

    always_comb
    begin
        addr  = prc_bus_pkg::LCD_CMD;
        wdata = pix;
        case (step)
            CP_COL_HI: wdata = prc_bus_pkg::LCD_COL_HI;
            CP_COL_LO: wdata = prc_bus_pkg::LCD_COL_LO;
            CP_PAGE:   wdata = prc_bus_pkg::LCD_PAGE + DW'(page);
            CP_READ:   addr  = prc_bus_pkg::FB_BASE + AW'(page) * AW'(`PRC_FB_COLUMNS) +
                               AW'(col);
            default:   addr  = prc_bus_pkg::LCD_DATA;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            req  <= 1'b0;
            step <= CP_COL_HI;
            page <= '0;
            col  <= '0;
        end
        else if (start)
        begin
            req  <= 1'b1;
            step <= CP_COL_HI;
            page <= '0;
            col  <= '0;
        end
        else if (ack)
        begin
            case (step)
                CP_COL_HI: step <= CP_COL_LO;
                CP_COL_LO: step <= CP_PAGE;
                CP_PAGE:   step <= CP_READ;
                CP_READ:   step <= CP_WRITE;
                default:
                begin
                    step <= last_col ? CP_COL_HI : CP_READ;  // New page restarts with commands
                    col  <= last_col ? '0 : col + 1'b1;
                    if (last_col && last_page)
                        req <= 1'b0;
                    else if (last_col)
                        page <= page + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack && step == CP_READ)
            pix <= rdata;
    end

endmodule

`default_nettype wire

//--- prc_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module prc_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  prc_reg_pkg::reg_offset_t     paddr,
    input  logic [`PRC_DATA_W-1:0]       pwdata,
    output logic [`PRC_DATA_W-1:0]       prdata,
    output logic                         mem_req,
    output logic [`PRC_ADDR_W-1:0]       mem_addr,
    output prc_bus_pkg::bus_op_t         mem_op,
    output logic [`PRC_DATA_W-1:0]       mem_wdata,
    input  logic                         mem_ack,
    input  logic [`PRC_DATA_W-1:0]       mem_rdata,
    output logic                         irq_render_done,
    output logic                         irq_copy_complete
);

    prc_reg_pkg::mode_t        mode;
    prc_reg_pkg::rate_sel_t    rate_sel;
    prc_reg_pkg::frame_count_t frame_count;
    logic [`PRC_ADDR_W-1:0]    map_base;
    logic [6:0]                line;
    logic                      render_enable;
    logic                      render_start;
    logic                      map_start;
    logic                      map_req;
    logic                      map_ack;
    logic                      map_done;
    logic                      copy_start;
    logic                      copy_req;
    logic                      copy_ack;
    logic                      copy_done;
    logic [`PRC_ADDR_W-1:0]    map_addr;
    logic [`PRC_ADDR_W-1:0]    copy_addr;
    prc_bus_pkg::bus_op_t      map_op;
    prc_bus_pkg::bus_op_t      copy_op;
    logic [`PRC_DATA_W-1:0]    map_wdata;
    logic [`PRC_DATA_W-1:0]    copy_wdata;
    logic [`PRC_DATA_W-1:0]    rdata;

    assign render_enable = mode[prc_reg_pkg::MODE_MAP_BIT] || mode[prc_reg_pkg::MODE_COPY_BIT];

    prc_regs u_regs (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .mode(mode), .rate_sel(rate_sel), .map_base(map_base),
        .frame_count(frame_count), .line(line)
    );

    prc_frame_timer u_timer (
        .clk(clk), .reset(reset),
        .rate_sel(rate_sel), .render_enable(render_enable),
        .frame_count(frame_count), .line(line),
        .render_start(render_start), .irq_render_done(irq_render_done)
    );

    prc_render_ctrl u_ctrl (
        .clk(clk), .reset(reset),
        .render_start(render_start), .mode(mode),
        .map_start(map_start), .copy_start(copy_start),
        .map_req(map_req), .map_addr(map_addr), .map_op(map_op), .map_wdata(map_wdata),
        .copy_req(copy_req), .copy_addr(copy_addr), .copy_op(copy_op),
        .copy_wdata(copy_wdata),
        .map_ack(map_ack), .copy_ack(copy_ack), .rdata(rdata),
        .map_done(map_done), .copy_done(copy_done),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_op(mem_op), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .irq_copy_complete(irq_copy_complete)
    );

    prc_map_draw u_map (
        .clk(clk), .reset(reset), .start(map_start),
        .req(map_req), .addr(map_addr), .op(map_op), .wdata(map_wdata),
        .ack(map_ack), .rdata(rdata), .done(map_done), .map_base(map_base)
    );

    prc_frame_copy u_copy (
        .clk(clk), .reset(reset), .start(copy_start),
        .ack(copy_ack), .rdata(rdata),
        .req(copy_req), .addr(copy_addr), .op(copy_op), .wdata(copy_wdata),
        .done(copy_done)
    );

endmodule

`default_nettype wire

//--- prc_checker.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module prc_checker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         mem_req,
    input  logic [`PRC_ADDR_W-1:0]       mem_addr,
    input  prc_bus_pkg::bus_op_t         mem_op,
    input  logic [`PRC_DATA_W-1:0]       mem_wdata,
    input  logic                         mem_ack,
    input  logic                         render_start,
    input  logic [6:0]                   line,
    input  logic                         irq_render_done,
    input  logic                         irq_copy_complete
);

    // A waiting request keeps its address and data until the ack
    a_request_held: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_op) &&
                                $stable(mem_wdata))
        else $error("memory request changed or dropped before its ack");

    a_idle_in_reset: assert property (@(posedge clk) reset |-> !mem_req)
        else $error("memory request raised during reset");

    a_render_done_pulse: assert property (@(posedge clk) disable iff (reset)
        irq_render_done |=> !irq_render_done)
        else $error("render-done interrupt longer than one cycle");

    a_copy_complete_pulse: assert property (@(posedge clk) disable iff (reset)
        irq_copy_complete |=> !irq_copy_complete)
        else $error("copy-complete interrupt longer than one cycle");

    // Render pass begins on the first cycle of the render line
    a_start_line: assert property (@(posedge clk) disable iff (reset)
        render_start |-> line == 7'(`PRC_RENDER_LINE))
        else $error("render start outside the render line");

endmodule

bind prc_top prc_checker i_checker (
    .clk(clk), .reset(reset),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_op(mem_op), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .render_start(render_start), .line(line),
    .irq_render_done(irq_render_done), .irq_copy_complete(irq_copy_complete)
);

`default_nettype wire

//--- tb_prc.sv
`default_nettype none
`timescale 1ns/10ps

`include "prc_config.svh"

module tb_prc;

    localparam int FB_BYTES     = `PRC_FB_COLUMNS * `PRC_FB_PAGES;
    localparam int FRAME_CYCLES = `PRC_LAST_LINE * `PRC_LINE_CYCLES;
    localparam logic [23:0] TILE_BASE = 24'h001800;

    logic                          clk;
    logic                          reset;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    prc_reg_pkg::reg_offset_t      paddr;
    logic [`PRC_DATA_W-1:0]        pwdata;
    logic [`PRC_DATA_W-1:0]        prdata;
    logic                          mem_req;
    logic [`PRC_ADDR_W-1:0]        mem_addr;
    prc_bus_pkg::bus_op_t          mem_op;
    logic [`PRC_DATA_W-1:0]        mem_wdata;
    logic                          mem_ack;
    logic [`PRC_DATA_W-1:0]        mem_rdata;
    logic                          irq_render_done;
    logic                          irq_copy_complete;

    logic [7:0] ram [0:65535];        // Work RAM indexed by the low 16 address bits
    logic [8:0] lcd_log [$];          // {is_data, byte}
    logic [7:0] fb_snap [0:FB_BYTES-1];
    int         cycle = 0;
    bit         pending;
    int         delay;

    prc_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic serve_request();
        logic [15:0] a;
        a = mem_addr[15:0];
        if (mem_op == prc_bus_pkg::WRITE)
        begin
            ram[a] = mem_wdata;
            if (mem_addr == prc_bus_pkg::LCD_CMD)
                lcd_log.push_back({1'b0, mem_wdata});
            else if (mem_addr == prc_bus_pkg::LCD_DATA)
                lcd_log.push_back({1'b1, mem_wdata});
        end
        else
            mem_rdata = ram[a];
        mem_ack = 1'b1;
    endtask

    // Memory slave with a random ack delay of 0 to 3 cycles
    always @(posedge clk)
    begin
        #1;
        mem_ack = 1'b0;
        if (mem_req && !reset)
        begin
            if (!pending)
            begin
                pending = 1'b1;
                delay   = $urandom_range(3, 0);
            end
            if (delay == 0)
            begin
                serve_request();
                pending = 1'b0;
            end
            else
                delay = delay - 1;
        end
    end

    task automatic apb_transfer(input bit write, input prc_reg_pkg::reg_offset_t offset,
                                input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        #1;
        psel   = 1'b1;
        pwrite = write;
        paddr  = offset;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic expect_read(input prc_reg_pkg::reg_offset_t offset,
                               input logic [7:0] expected, input string what);
        logic [7:0] rd;
        apb_transfer(1'b0, offset, 8'h00, rd);
        assert (rd == expected)
        else abort_run($sformatf("error at %0d ns: %s read %h, expected %h",
                                 $time, what, rd, expected));
    endtask

    task automatic wait_for_irq(input bit copy_irq, input int limit, input string what);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen)
        begin
            @(negedge clk);
            seen   = copy_irq ? irq_copy_complete : irq_render_done;
            waited = waited + 1;
            if (!seen && waited > limit)
                abort_run({"Timed out waiting for ", what});
        end
    endtask

    task automatic check_map_result();
        logic [7:0] idx;
        logic [7:0] expected;
        for (int p = 0; p < `PRC_FB_PAGES; p++)
            for (int c = 0; c < `PRC_FB_COLUMNS; c++)
            begin
                idx      = ram[16'(prc_bus_pkg::MAP_BASE + p * `PRC_MAP_COLUMNS + c / 8)];
                expected = ram[16'(TILE_BASE + idx * 8 + c % 8)];
                assert (ram[16'(prc_bus_pkg::FB_BASE + p * `PRC_FB_COLUMNS + c)] == expected)
                else abort_run($sformatf("error at %0d ns: frame buffer page %0d column %0d",
                                         $time, p, c));
            end
    endtask

    task automatic check_lcd_log();
        int k;
        assert (lcd_log.size() == `PRC_FB_PAGES * (3 + `PRC_FB_COLUMNS))
        else abort_run($sformatf("error at %0d ns: LCD log holds %0d entries",
                                 $time, lcd_log.size()));
        k = 0;
        for (int p = 0; p < `PRC_FB_PAGES; p++)
        begin
            assert (lcd_log[k] == {1'b0, prc_bus_pkg::LCD_COL_HI} &&
                    lcd_log[k+1] == {1'b0, prc_bus_pkg::LCD_COL_LO} &&
                    lcd_log[k+2] == {1'b0, 8'(prc_bus_pkg::LCD_PAGE + p)})
            else abort_run($sformatf("error at %0d ns: LCD commands of page %0d", $time, p));
            k = k + 3;
            for (int c = 0; c < `PRC_FB_COLUMNS; c++)
            begin
                assert (lcd_log[k] ==
                        {1'b1, ram[16'(prc_bus_pkg::FB_BASE + p * `PRC_FB_COLUMNS + c)]})
                else abort_run($sformatf("error at %0d ns: LCD data page %0d column %0d",
                                         $time, p, c));
                k = k + 1;
            end
        end
    endtask

    initial
    begin
        logic [7:0] rd;
        int         t0;
        void'($urandom(32'h1059_02e1));
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        pending   = 1'b0;
        delay     = 0;
        for (int a = 0; a < 65536; a++)
            ram[a] = 8'(a ^ (a >> 8));
        for (int a = 0; a < 2048; a++)
            ram[16'(TILE_BASE + a)] = 8'($urandom);
        for (int a = 0; a < `PRC_FB_PAGES * `PRC_MAP_COLUMNS; a++)
            ram[16'(prc_bus_pkg::MAP_BASE + a)] = 8'($urandom);
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        // Register readback with the sprite bit set and both render bits clear
        apb_transfer(1'b1, prc_reg_pkg::REG_MODE, 8'hF5, rd);
        expect_read(prc_reg_pkg::REG_MODE, 8'hF5 & 8'h3F, "mode");
        apb_transfer(1'b1, prc_reg_pkg::REG_MAP_BASE_LO, 8'hFF, rd);
        apb_transfer(1'b1, prc_reg_pkg::REG_MAP_BASE_MID, 8'hA5, rd);
        apb_transfer(1'b1, prc_reg_pkg::REG_MAP_BASE_HI, 8'hFF, rd);
        expect_read(prc_reg_pkg::REG_MAP_BASE_LO, 8'hF8, "map base low");
        expect_read(prc_reg_pkg::REG_MAP_BASE_MID, 8'hA5, "map base middle");
        expect_read(prc_reg_pkg::REG_MAP_BASE_HI, 8'h1F, "map base high");
        for (int off = 5; off < 10; off++)
            expect_read(4'(off), 8'h00, "unused offset");
        repeat (3)
        begin
            apb_transfer(1'b0, prc_reg_pkg::REG_COUNTER, 8'h00, rd);
            assert (rd >= 8'd1 && rd <= 8'(`PRC_LAST_LINE))
            else abort_run($sformatf("error at %0d ns: line counter reads %0d", $time, rd));
            repeat (20000) @(posedge clk);
        end

        // Full pass at divisor 2
        apb_transfer(1'b1, prc_reg_pkg::REG_MAP_BASE_LO, TILE_BASE[7:0], rd);
        apb_transfer(1'b1, prc_reg_pkg::REG_MAP_BASE_MID, TILE_BASE[15:8], rd);
        apb_transfer(1'b1, prc_reg_pkg::REG_MAP_BASE_HI, TILE_BASE[23:16], rd);
        apb_transfer(1'b1, prc_reg_pkg::REG_RATE, 8'h08, rd);
        lcd_log.delete();
        apb_transfer(1'b1, prc_reg_pkg::REG_MODE, 8'h0A, rd);
        wait_for_irq(1'b1, 4 * FRAME_CYCLES, "the first copy-complete interrupt");
        check_map_result();
        check_lcd_log();

        wait_for_irq(1'b0, 2 * FRAME_CYCLES + 100, "a render-done interrupt");
        t0 = cycle;
        wait_for_irq(1'b0, 2 * FRAME_CYCLES + 100, "the next render-done interrupt");
        assert (cycle - t0 == 2 * FRAME_CYCLES)
        else abort_run($sformatf("error at %0d ns: render-done spacing %0d at divisor 2",
                                 $time, cycle - t0));

        apb_transfer(1'b1, prc_reg_pkg::REG_RATE, 8'h00, rd);
        wait_for_irq(1'b0, 4 * FRAME_CYCLES, "render done after the rate change");
        t0 = cycle;
        wait_for_irq(1'b0, 3 * FRAME_CYCLES + 100, "render done at divisor 3");
        assert (cycle - t0 == 3 * FRAME_CYCLES)
        else abort_run($sformatf("error at %0d ns: render-done spacing %0d at divisor 3",
                                 $time, cycle - t0));

        // Copy-only pass leaves a fresh frame buffer untouched
        apb_transfer(1'b1, prc_reg_pkg::REG_MODE, 8'h08, rd);
        for (int a = 0; a < FB_BYTES; a++)
        begin
            fb_snap[a] = 8'($urandom);
            ram[16'(prc_bus_pkg::FB_BASE + a)] = fb_snap[a];
        end
        lcd_log.delete();
        wait_for_irq(1'b1, 4 * FRAME_CYCLES, "the copy-only pass");
        for (int a = 0; a < FB_BYTES; a++)
            assert (ram[16'(prc_bus_pkg::FB_BASE + a)] == fb_snap[a])
            else abort_run($sformatf("error at %0d ns: frame buffer byte %0d changed",
                                     $time, a));
        check_lcd_log();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
prc_reg_pkg.sv
prc_bus_pkg.sv
prc_regs.sv
prc_frame_timer.sv
prc_render_ctrl.sv
prc_map_draw.sv
prc_frame_copy.sv
prc_top.sv
prc_checker.sv
tb_prc.sv

//--- run.sh
#!/bin/sh
# Build the PRC testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --timescale 1ns/10ps --top-module tb_prc -f src.f

out=$(./obj_dir/Vtb_prc || true)
echo "$out"
echo "$out" | grep -q "Everything OK"
